/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_cart_core
OBJ_DIR ?= obj_dir
FLAGS ?= --binary --assert --timing --timescale 1ns/1ps

FILE_LIST := verilog.f
SOURCES := $(filter-out +%,$(shell cat $(FILE_LIST)))
BINARY := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

# Rebuilt only when the file list or a source changes
$(BINARY): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# The exit status of the simulation is the result
run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf $(OBJ_DIR)

/* src/bus_pkg.sv */
package bus_pkg;

    // Byte address from a master, 32-bit data words
    localparam int ADDR_W = 26;
    localparam int DATA_W = 32;

    // Values not listed here are unmapped
    typedef enum logic [3:0] {
        BANK_CART   = 4'd1,
        BANK_SDRAM  = 4'd2,
        BANK_EEPROM = 4'd3
    } bank_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_WAIT_ACK
    } arb_state_t;

endpackage

/* src/cart_control.sv */
module cart_control
    import bus_pkg::*;
    import cart_regs_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,

    input  logic              i_request,
    input  logic              i_write,
    input  reg_addr_t         i_address,
    input  logic [DATA_W-1:0] i_data,
    output logic              o_ack,
    output logic [DATA_W-1:0] o_data,

    output logic              o_eeprom_16k_mode
);

    logic [DATA_W-1:0] scratch;
    logic [DATA_W-1:0] read_data;

    always_comb begin
        case (i_address)
            REG_VERSION: read_data = CART_VERSION;
            REG_SCRATCH: read_data = scratch;
            REG_CONFIG:  read_data = {{(DATA_W - 1){1'b0}}, o_eeprom_16k_mode};
            default:     read_data = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_ack <= 1'b0;
            scratch <= '0;
            o_eeprom_16k_mode <= 1'b0;
        end else begin
            o_ack <= i_request;
            if (i_request && i_write) begin
                // Version register is read only
                case (i_address)
                    REG_SCRATCH: scratch <= i_data;
                    REG_CONFIG:  o_eeprom_16k_mode <= i_data[0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_request) begin
            o_data <= read_data;
        end
    end

endmodule

/* src/cart_core.sv */
module cart_core
    import bus_pkg::*;
    import cart_regs_pkg::*;
#(
    parameter int MEM_WORDS = 1024,
    parameter int LED_HOLD = 8
) (
    input  logic              i_clk,
    input  logic              i_rst_n,

    input  logic              i_n64_request,
    input  logic              i_n64_write,
    input  bank_t             i_n64_bank,
    input  logic [ADDR_W-1:0] i_n64_address,
    input  logic [DATA_W-1:0] i_n64_data,
    output logic              o_n64_busy,
    output logic              o_n64_ack,
    output logic [DATA_W-1:0] o_n64_data,

    input  logic              i_pc_request,
    input  logic              i_pc_write,
    input  bank_t             i_pc_bank,
    input  logic [ADDR_W-1:0] i_pc_address,
    input  logic [DATA_W-1:0] i_pc_data,
    output logic              o_pc_busy,
    output logic              o_pc_ack,
    output logic [DATA_W-1:0] o_pc_data,

    output logic              o_led
);

    localparam int SDRAM_ADDR_W = $clog2(MEM_WORDS);

    // Master side, index 0 is n64 and index 1 is pc
    logic [1:0] w_request;
    logic [1:0] w_write;
    bank_t w_bank [2];
    logic [ADDR_W-1:0] w_address [2];
    logic [DATA_W-1:0] w_wdata [2];
    logic [1:0] w_busy;
    logic [1:0] w_ack;
    logic [DATA_W-1:0] w_rdata [2];

    logic [1:0] w_cart_address [2];
    logic [8:0] w_eeprom_address [2];
    logic [SDRAM_ADDR_W-1:0] w_sdram_address [2];

    assign w_request = {i_pc_request, i_n64_request};
    assign w_write = {i_pc_write, i_n64_write};
    assign w_bank[0] = i_n64_bank;
    assign w_bank[1] = i_pc_bank;
    assign w_address[0] = i_n64_address;
    assign w_address[1] = i_pc_address;
    assign w_wdata[0] = i_n64_data;
    assign w_wdata[1] = i_pc_data;

    always_comb begin
        for (int m = 0; m < 2; m++) begin
            w_cart_address[m] = w_address[m][3:2];
            w_eeprom_address[m] = w_address[m][10:2];
            w_sdram_address[m] = w_address[m][SDRAM_ADDR_W+1:2];
        end
    end

    // Cart control registers
    logic [1:0] w_cart_busy;
    logic [1:0] w_cart_ack;
    logic [DATA_W-1:0] w_cart_rdata [2];
    logic w_cart_request;
    logic w_cart_write;
    logic [1:0] w_cart_dev_address;
    logic [DATA_W-1:0] w_cart_dev_wdata;
    logic w_cart_dev_ack;
    logic [DATA_W-1:0] w_cart_dev_rdata;
    reg_addr_t w_cart_reg;
    logic w_eeprom_16k_mode;

    assign w_cart_reg = reg_addr_t'(w_cart_dev_address);

    device_arbiter #(
        .NUM_MASTERS(2),
        .ADDRESS_WIDTH(2),
        .DEVICE_BANK(BANK_CART)
    ) device_arbiter_cart_inst (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_request(w_request),
        .i_write(w_write),
        .i_bank(w_bank),
        .i_address(w_cart_address),
        .i_data(w_wdata),
        .o_busy(w_cart_busy),
        .o_ack(w_cart_ack),
        .o_data(w_cart_rdata),
        .o_device_request(w_cart_request),
        .o_device_write(w_cart_write),
        .o_device_address(w_cart_dev_address),
        .o_device_data(w_cart_dev_wdata),
        .i_device_ack(w_cart_dev_ack),
        .i_device_data(w_cart_dev_rdata)
    );

    cart_control cart_control_inst (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_request(w_cart_request),
        .i_write(w_cart_write),
        .i_address(w_cart_reg),
        .i_data(w_cart_dev_wdata),
        .o_ack(w_cart_dev_ack),
        .o_data(w_cart_dev_rdata),
        .o_eeprom_16k_mode(w_eeprom_16k_mode)
    );

    // SDRAM model
    logic [1:0] w_sdram_busy;
    logic [1:0] w_sdram_ack;
    logic [DATA_W-1:0] w_sdram_rdata [2];
    logic w_sdram_request;
    logic w_sdram_write;
    logic [SDRAM_ADDR_W-1:0] w_sdram_dev_address;
    logic [DATA_W-1:0] w_sdram_dev_wdata;
    logic w_sdram_dev_ack;
    logic [DATA_W-1:0] w_sdram_dev_rdata;

    device_arbiter #(
        .NUM_MASTERS(2),
        .ADDRESS_WIDTH(SDRAM_ADDR_W),
        .DEVICE_BANK(BANK_SDRAM)
    ) device_arbiter_sdram_inst (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_request(w_request),
        .i_write(w_write),
        .i_bank(w_bank),
        .i_address(w_sdram_address),
        .i_data(w_wdata),
        .o_busy(w_sdram_busy),
        .o_ack(w_sdram_ack),
        .o_data(w_sdram_rdata),
        .o_device_request(w_sdram_request),
        .o_device_write(w_sdram_write),
        .o_device_address(w_sdram_dev_address),
        .o_device_data(w_sdram_dev_wdata),
        .i_device_ack(w_sdram_dev_ack),
        .i_device_data(w_sdram_dev_rdata)
    );

    sdram_memory #(
        .MEM_WORDS(MEM_WORDS)
    ) sdram_memory_inst (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_request(w_sdram_request),
        .i_write(w_sdram_write),
        .i_address(w_sdram_dev_address),
        .i_data(w_sdram_dev_wdata),
        .o_ack(w_sdram_dev_ack),
        .o_data(w_sdram_dev_rdata)
    );

    // EEPROM save memory
    logic [1:0] w_eeprom_busy;
    logic [1:0] w_eeprom_ack;
    logic [DATA_W-1:0] w_eeprom_rdata [2];
    logic w_eeprom_request;
    logic w_eeprom_write;
    logic [8:0] w_eeprom_dev_address;
    logic [DATA_W-1:0] w_eeprom_dev_wdata;
    logic w_eeprom_dev_ack;
    logic [DATA_W-1:0] w_eeprom_dev_rdata;

    device_arbiter #(
        .NUM_MASTERS(2),
        .ADDRESS_WIDTH(9),
        .DEVICE_BANK(BANK_EEPROM)
    ) device_arbiter_eeprom_inst (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_request(w_request),
        .i_write(w_write),
        .i_bank(w_bank),
        .i_address(w_eeprom_address),
        .i_data(w_wdata),
        .o_busy(w_eeprom_busy),
        .o_ack(w_eeprom_ack),
        .o_data(w_eeprom_rdata),
        .o_device_request(w_eeprom_request),
        .o_device_write(w_eeprom_write),
        .o_device_address(w_eeprom_dev_address),
        .o_device_data(w_eeprom_dev_wdata),
        .i_device_ack(w_eeprom_dev_ack),
        .i_device_data(w_eeprom_dev_rdata)
    );

    eeprom_memory eeprom_memory_inst (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_request(w_eeprom_request),
        .i_write(w_eeprom_write),
        .i_address(w_eeprom_dev_address),
        .i_data(w_eeprom_dev_wdata),
        .i_16k_mode(w_eeprom_16k_mode),
        .o_ack(w_eeprom_dev_ack),
        .o_data(w_eeprom_dev_rdata)
    );

    // One response per master
    for (genvar m = 0; m < 2; m++) begin : g_merge
        logic [DATA_W-1:0] w_dev_data [3];

        assign w_dev_data[0] = w_cart_rdata[m];
        assign w_dev_data[1] = w_sdram_rdata[m];
        assign w_dev_data[2] = w_eeprom_rdata[m];

        response_merge #(
            .NUM_DEVICES(3)
        ) response_merge_inst (
            .i_clk(i_clk),
            .i_rst_n(i_rst_n),
            .i_request(w_request[m]),
            .i_bank(w_bank[m]),
            .i_busy({w_eeprom_busy[m], w_sdram_busy[m], w_cart_busy[m]}),
            .i_ack({w_eeprom_ack[m], w_sdram_ack[m], w_cart_ack[m]}),
            .i_data(w_dev_data),
            .o_busy(w_busy[m]),
            .o_ack(w_ack[m]),
            .o_data(w_rdata[m])
        );
    end

    assign o_n64_busy = w_busy[0];
    assign o_n64_ack = w_ack[0];
    assign o_n64_data = w_rdata[0];
    assign o_pc_busy = w_busy[1];
    assign o_pc_ack = w_ack[1];
    assign o_pc_data = w_rdata[1];

    // Activity LED
    logic w_led_trigger;

    assign w_led_trigger = (w_request[0] && !w_busy[0]) || (w_request[1] && !w_busy[1]);

    cart_led #(
        .LED_HOLD(LED_HOLD)
    ) cart_led_inst (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_trigger(w_led_trigger),
        .o_led(o_led)
    );

endmodule

/* src/cart_led.sv */
module cart_led #(
    parameter int LED_HOLD = 8
) (
    input  logic i_clk,
    input  logic i_rst_n,

    input  logic i_trigger,
    output logic o_led
);

    logic [$clog2(LED_HOLD + 1)-1:0] hold_count;

    // Each new trigger restarts the hold time
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            hold_count <= '0;
        end else if (i_trigger) begin
            hold_count <= ($clog2(LED_HOLD + 1))'(LED_HOLD);
        end else if (hold_count != '0) begin
            hold_count <= hold_count - 1'b1;
        end
    end

    assign o_led = (hold_count != '0);

endmodule

/* src/cart_regs_pkg.sv */
package cart_regs_pkg;

    // Word index inside the cart control bank
    typedef enum logic [1:0] {
        REG_VERSION = 2'd0,
        REG_SCRATCH = 2'd1,
        REG_CONFIG  = 2'd2
    } reg_addr_t;

    localparam logic [31:0] CART_VERSION = 32'h0002_0104;

    // Save sizes in 32-bit words
    localparam int EEPROM_4K_WORDS  = 128;
    localparam int EEPROM_16K_WORDS = 512;

endpackage

/* src/device_arbiter.sv */
module device_arbiter
    import bus_pkg::*;
#(
    parameter int NUM_MASTERS = 2,
    parameter int ADDRESS_WIDTH = 9,
    parameter bank_t DEVICE_BANK = BANK_CART
) (
    input  logic                     i_clk,
    input  logic                     i_rst_n,

    input  logic [NUM_MASTERS-1:0]   i_request,
    input  logic [NUM_MASTERS-1:0]   i_write,
    input  bank_t                    i_bank [NUM_MASTERS],
    input  logic [ADDRESS_WIDTH-1:0] i_address [NUM_MASTERS],
    input  logic [DATA_W-1:0]        i_data [NUM_MASTERS],
    output logic [NUM_MASTERS-1:0]   o_busy,
    output logic [NUM_MASTERS-1:0]   o_ack,
    output logic [DATA_W-1:0]        o_data [NUM_MASTERS],

    output logic                     o_device_request,
    output logic                     o_device_write,
    output logic [ADDRESS_WIDTH-1:0] o_device_address,
    output logic [DATA_W-1:0]        o_device_data,
    input  logic                     i_device_ack,
    input  logic [DATA_W-1:0]        i_device_data
);

    localparam int IDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

    arb_state_t state;
    logic [IDX_W-1:0] grant;
    logic [IDX_W-1:0] winner;
    logic winner_valid;
    logic [NUM_MASTERS-1:0] contender;

    // Scan downwards so the lowest index ends up as winner
    always_comb begin
        winner = '0;
        winner_valid = 1'b0;
        for (int i = NUM_MASTERS - 1; i >= 0; i--) begin
            contender[i] = i_request[i] && (i_bank[i] == DEVICE_BANK);
            if (contender[i]) begin
                winner = IDX_W'(i);
                winner_valid = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_MASTERS; i++) begin
            if (state == ARB_IDLE) begin
                o_busy[i] = contender[i] && (winner != IDX_W'(i));
            end else begin
                o_busy[i] = contender[i];
            end
            o_ack[i] = (state == ARB_WAIT_ACK) && i_device_ack && (grant == IDX_W'(i));
            o_data[i] = (grant == IDX_W'(i)) ? i_device_data : '0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= ARB_IDLE;
            grant <= '0;
            o_device_request <= 1'b0;
        end else begin
            o_device_request <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    if (winner_valid) begin
                        state <= ARB_WAIT_ACK;
                        grant <= winner;
                        o_device_request <= 1'b1;
                    end
                end
                ARB_WAIT_ACK: begin
                    if (i_device_ack) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Latch the winner's transaction at acceptance
    always_ff @(posedge i_clk) begin
        if (state == ARB_IDLE && winner_valid) begin
            o_device_write <= i_write[winner];
            o_device_address <= i_address[winner];
            o_device_data <= i_data[winner];
        end
    end

endmodule

/* src/eeprom_memory.sv */
module eeprom_memory
    import bus_pkg::*;
    import cart_regs_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,

    input  logic              i_request,
    input  logic              i_write,
    input  logic [8:0]        i_address,
    input  logic [DATA_W-1:0] i_data,
    input  logic              i_16k_mode,
    output logic              o_ack,
    output logic [DATA_W-1:0] o_data
);

    logic [DATA_W-1:0] mem [EEPROM_16K_WORDS];
    logic [8:0] word_address;

    // 4k parts alias every 128 words
    assign word_address = i_16k_mode ? i_address : (i_address & 9'(EEPROM_4K_WORDS - 1));

    always_ff @(posedge i_clk) begin
        if (i_request) begin
            if (i_write) begin
                mem[word_address] <= i_data;
            end
            o_data <= mem[word_address];
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_request;
        end
    end

endmodule

/* src/response_merge.sv */
module response_merge
    import bus_pkg::*;
#(
    parameter int NUM_DEVICES = 3
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,

    input  logic                   i_request,
    input  bank_t                  i_bank,

    input  logic [NUM_DEVICES-1:0] i_busy,
    input  logic [NUM_DEVICES-1:0] i_ack,
    input  logic [DATA_W-1:0]      i_data [NUM_DEVICES],

    output logic                   o_busy,
    output logic                   o_ack,
    output logic [DATA_W-1:0]      o_data
);

    logic unmapped;
    logic unmapped_ack;

    assign unmapped = !(i_bank inside {BANK_CART, BANK_SDRAM, BANK_EEPROM});

    // No arbiter answers these, so ack them here
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            unmapped_ack <= 1'b0;
        end else begin
            unmapped_ack <= i_request && unmapped;
        end
    end

    assign o_busy = |i_busy;
    assign o_ack = (|i_ack) || unmapped_ack;

    always_comb begin
        o_data = '0;
        for (int i = 0; i < NUM_DEVICES; i++) begin
            if (i_ack[i]) begin
                o_data = i_data[i];
            end
        end
    end

endmodule

/* src/sdram_memory.sv */
module sdram_memory
    import bus_pkg::*;
#(
    parameter int MEM_WORDS = 1024
) (
    input  logic                         i_clk,
    input  logic                         i_rst_n,

    input  logic                         i_request,
    input  logic                         i_write,
    input  logic [$clog2(MEM_WORDS)-1:0] i_address,
    input  logic [DATA_W-1:0]            i_data,
    output logic                         o_ack,
    output logic [DATA_W-1:0]            o_data
);

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [DATA_W-1:0] stage_data;
    logic stage_valid;

    // Array read, then output register
    always_ff @(posedge i_clk) begin
        if (i_request) begin
            if (i_write) begin
                mem[i_address] <= i_data;
            end
            stage_data <= mem[i_address];
        end
        o_data <= stage_data;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            stage_valid <= 1'b0;
            o_ack <= 1'b0;
        end else begin
            stage_valid <= i_request;
            o_ack <= stage_valid;
        end
    end

endmodule

/* test/cart_core_properties.sv */
module cart_core_properties
    import bus_pkg::*;
#(
    parameter int NUM_MASTERS = 2
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  arb_state_t             i_state,
    input  logic [NUM_MASTERS-1:0] i_contender,
    input  logic [NUM_MASTERS-1:0] i_busy,
    input  logic                   i_device_request,
    input  logic                   i_device_ack
);
    timeunit 1ns;
    timeprecision 1ps;

    logic outstanding;

    // Set by a device request, cleared by its ack
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            outstanding <= 1'b0;
        end else if (i_device_request) begin
            outstanding <= 1'b1;
        end else if (i_device_ack) begin
            outstanding <= 1'b0;
        end
    end

    a_single_request: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_state == ARB_WAIT_ACK && i_device_request) |=> !i_device_request)
        else $error("device request high in two consecutive cycles");

    a_ack_after_request: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_device_ack |-> outstanding)
        else $error("device ack without an earlier request");

    a_winner_not_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_state == ARB_IDLE && |i_contender) |-> |(i_contender & ~i_busy))
        else $error("no contender accepted while idle");

endmodule

/* test/tb_cart_core.sv */
module tb_cart_core
    import bus_pkg::*;
    import cart_regs_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS = 1024;
    localparam int LED_HOLD = 8;
    localparam int TIMEOUT = 50;

    logic clk = 1'b0;
    logic rst_n;
    logic led;

    // Index 0 is the n64 port, index 1 the pc port
    logic [1:0] m_request;
    logic [1:0] m_write;
    bank_t m_bank [2];
    logic [ADDR_W-1:0] m_address [2];
    logic [DATA_W-1:0] m_wdata [2];
    logic [1:0] m_busy;
    logic [1:0] m_ack;
    logic [DATA_W-1:0] m_rdata [2];

    int cycle = 0;
    int ack_count [2];
    int accept_cycle [2];
    int accept_wait [2];
    int ack_cycle [2];
    logic [15:0] lfsr = 16'd24891;

    // Reference model
    logic [DATA_W-1:0] sdram_model [MEM_WORDS];
    logic sdram_written [MEM_WORDS];
    logic [DATA_W-1:0] eeprom_model [EEPROM_16K_WORDS];
    logic [DATA_W-1:0] scratch_model;
    logic mode_16k;

    cart_core #(
        .MEM_WORDS(MEM_WORDS),
        .LED_HOLD(LED_HOLD)
    ) i_cart_core (
        .i_clk(clk),
        .i_rst_n(rst_n),
        .i_n64_request(m_request[0]),
        .i_n64_write(m_write[0]),
        .i_n64_bank(m_bank[0]),
        .i_n64_address(m_address[0]),
        .i_n64_data(m_wdata[0]),
        .o_n64_busy(m_busy[0]),
        .o_n64_ack(m_ack[0]),
        .o_n64_data(m_rdata[0]),
        .i_pc_request(m_request[1]),
        .i_pc_write(m_write[1]),
        .i_pc_bank(m_bank[1]),
        .i_pc_address(m_address[1]),
        .i_pc_data(m_wdata[1]),
        .o_pc_busy(m_busy[1]),
        .o_pc_ack(m_ack[1]),
        .o_pc_data(m_rdata[1]),
        .o_led(led)
    );

    bind device_arbiter cart_core_properties #(
        .NUM_MASTERS(NUM_MASTERS)
    ) properties_inst (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_state(state),
        .i_contender(contender),
        .i_busy(o_busy),
        .i_device_request(o_device_request),
        .i_device_ack(i_device_ack)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    always @(negedge clk) begin
        if (m_ack[0]) begin
            ack_count[0] = ack_count[0] + 1;
        end
        if (m_ack[1]) begin
            ack_count[1] = ack_count[1] + 1;
        end
    end

    // Galois LFSR, taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic logic [8:0] eeprom_index(input logic [9:0] word);
        return mode_16k ? word[8:0] : {2'b00, word[6:0]};
    endfunction

    function automatic logic [DATA_W-1:0] model_read(input bank_t bank, input logic [9:0] word);
        case (bank)
            BANK_CART: begin
                case (reg_addr_t'(word[1:0]))
                    REG_VERSION: return CART_VERSION;
                    REG_SCRATCH: return scratch_model;
                    REG_CONFIG:  return {{(DATA_W - 1){1'b0}}, mode_16k};
                    default:     return '0;
                endcase
            end
            BANK_SDRAM:  return sdram_model[word];
            BANK_EEPROM: return eeprom_model[eeprom_index(word)];
            default:     return '0;
        endcase
    endfunction

    task automatic model_write(input bank_t bank, input logic [9:0] word,
                               input logic [DATA_W-1:0] data);
        case (bank)
            BANK_CART: begin
                if (reg_addr_t'(word[1:0]) == REG_SCRATCH) begin
                    scratch_model = data;
                end else if (reg_addr_t'(word[1:0]) == REG_CONFIG) begin
                    mode_16k = data[0];
                end
            end
            BANK_SDRAM: begin
                sdram_model[word] = data;
                sdram_written[word] = 1'b1;
            end
            BANK_EEPROM: eeprom_model[eeprom_index(word)] = data;
            default: ;
        endcase
    endtask

    function automatic int expected_latency(input bank_t bank);
        case (bank)
            BANK_SDRAM:             return 3;
            BANK_CART, BANK_EEPROM: return 2;
            default:                return 1;
        endcase
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bank_ack(input string name, input bank_t bank, input int count);
        if (count != 1) begin
            $display("FAILED %s: bank %0d expected 1 ack, actual %0d", name, bank, count);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_cycles(input string name, input int expected, input int actual,
                                input int tolerance);
        if (actual < expected - tolerance || actual > expected + tolerance) begin
            $display("FAILED %s: expected %0d +/- %0d cycles, actual %0d",
                     name, expected, tolerance, actual);
            abort_run();
        end
    endtask

    task automatic run_transaction(input int m, input logic write, input bank_t bank,
                                   input logic [9:0] word, input logic [DATA_W-1:0] data,
                                   output logic [DATA_W-1:0] rdata);
        int waited;
        @(negedge clk);
        m_request[m] = 1'b1;
        m_write[m] = write;
        m_bank[m] = bank;
        m_address[m] = {{(ADDR_W - 12){1'b0}}, word, 2'b00};
        m_wdata[m] = data;
        #1;
        waited = 0;
        while (m_busy[m]) begin
            if (waited == TIMEOUT) begin
                $display("Timeout: master %0d request was never accepted", m);
                abort_run();
            end
            @(negedge clk);
            #1;
            waited++;
        end
        accept_cycle[m] = cycle;
        accept_wait[m] = waited;
        @(negedge clk);
        m_request[m] = 1'b0;
        #1;
        waited = 0;
        while (!m_ack[m]) begin
            if (waited == TIMEOUT) begin
                $display("Timeout: master %0d got no ack after acceptance", m);
                abort_run();
            end
            @(negedge clk);
            #1;
            waited++;
        end
        ack_cycle[m] = cycle;
        rdata = m_rdata[m];
    endtask

    task automatic access(input string name, input int m, input logic write, input bank_t bank,
                          input logic [9:0] word, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] rdata;
        int start_count;
        start_count = ack_count[m];
        run_transaction(m, write, bank, word, data, rdata);
        check_cycles(name, expected_latency(bank), ack_cycle[m] - accept_cycle[m], 0);
        if (write) begin
            model_write(bank, word, data);
        end else begin
            check_data(name, model_read(bank, word), rdata);
        end
        // Leave room for a stray second ack
        @(negedge clk);
        @(negedge clk);
        #1;
        check_bank_ack(name, bank, ack_count[m] - start_count);
    endtask

    task automatic contend(input string name, input bank_t bank, input logic [9:0] word);
        logic [DATA_W-1:0] data;
        data = take_bits(32);
        fork
            access({name, " n64 write"}, 0, 1'b1, bank, word, data);
            access({name, " pc read"}, 1, 1'b0, bank, word, '0);
        join
        check_cycles({name, " n64 accept"}, 0, accept_wait[0], 0);
        check_bit({name, " pc held until n64 ack"}, 1'b1, accept_cycle[1] > ack_cycle[0]);
    endtask

    task automatic wait_led_low(output int fall_cycle);
        int waited;
        waited = 0;
        while (led) begin
            if (waited == TIMEOUT) begin
                $display("Timeout: activity LED never turned off");
                abort_run();
            end
            @(negedge clk);
            #1;
            waited++;
        end
        fall_cycle = cycle;
    endtask

    initial begin
        logic [31:0] r;
        logic write;
        logic [9:0] word;
        logic [6:0] a7;
        logic [DATA_W-1:0] data;
        int fall;

        rst_n = 1'b0;
        m_request = '0;
        m_write = '0;
        for (int m = 0; m < 2; m++) begin
            m_bank[m] = BANK_CART;
            m_address[m] = '0;
            m_wdata[m] = '0;
            ack_count[m] = 0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            sdram_written[i] = 1'b0;
        end
        scratch_model = '0;
        mode_16k = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_bit("reset n64 busy", 1'b0, m_busy[0]);
        check_bit("reset pc ack", 1'b0, m_ack[1]);
        check_bit("reset led", 1'b0, led);

        // Cart registers
        access("version read", 0, 1'b0, BANK_CART, 10'(REG_VERSION), '0);
        access("version write", 1, 1'b1, BANK_CART, 10'(REG_VERSION), take_bits(32));
        access("version reread", 1, 1'b0, BANK_CART, 10'(REG_VERSION), '0);
        access("scratch n64 write", 0, 1'b1, BANK_CART, 10'(REG_SCRATCH), take_bits(32));
        access("scratch pc read", 1, 1'b0, BANK_CART, 10'(REG_SCRATCH), '0);
        access("scratch pc write", 1, 1'b1, BANK_CART, 10'(REG_SCRATCH), take_bits(32));
        access("scratch n64 read", 0, 1'b0, BANK_CART, 10'(REG_SCRATCH), '0);

        // EEPROM aliasing in 4k mode, then distinct words in 16k mode
        a7 = 7'(take_bits(7));
        data = take_bits(32);
        access("eeprom 4k write", 0, 1'b1, BANK_EEPROM, {3'b000, a7}, data);
        access("eeprom 4k alias read", 1, 1'b0, BANK_EEPROM, {3'b001, a7}, '0);
        access("config 16k write", 0, 1'b1, BANK_CART, 10'(REG_CONFIG), 32'h1);
        access("config 16k read", 1, 1'b0, BANK_CART, 10'(REG_CONFIG), '0);
        access("eeprom 16k write", 1, 1'b1, BANK_EEPROM, {3'b001, a7}, ~data);
        access("eeprom 16k low read", 0, 1'b0, BANK_EEPROM, {3'b000, a7}, '0);
        access("eeprom 16k high read", 0, 1'b0, BANK_EEPROM, {3'b001, a7}, '0);

        // Random SDRAM traffic
        for (int i = 0; i < 200; i++) begin
            r = take_bits(1);
            write = r[0];
            word = 10'(take_bits(10));
            data = take_bits(32);
            r = take_bits(1);
            if (!write && !sdram_written[word]) begin
                write = 1'b1;
            end
            access("sdram random", int'(r[0]), write, BANK_SDRAM, word, data);
        end

        contend("contention cart", BANK_CART, 10'(REG_SCRATCH));
        contend("contention sdram", BANK_SDRAM, 10'(take_bits(10)));

        // Unmapped banks answer zero and change nothing
        access("sdram before unmapped", 1, 1'b1, BANK_SDRAM, 10'd1, take_bits(32));
        access("unmapped read", 0, 1'b0, bank_t'(4'd0), 10'd1, '0);
        access("unmapped write", 1, 1'b1, bank_t'(4'd9), 10'd1, take_bits(32));
        access("unmapped keeps scratch", 0, 1'b0, BANK_CART, 10'(REG_SCRATCH), '0);
        access("unmapped keeps sdram", 0, 1'b0, BANK_SDRAM, 10'd1, '0);

        // Activity LED
        wait_led_low(fall);
        access("led trigger read", 0, 1'b0, BANK_CART, 10'(REG_VERSION), '0);
        check_bit("led on after request", 1'b1, led);
        wait_led_low(fall);
        check_cycles("led hold", LED_HOLD, fall - accept_cycle[0] - 1, 2);

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* verilog.f */
src/bus_pkg.sv
src/cart_regs_pkg.sv
src/device_arbiter.sv
src/response_merge.sv
src/cart_control.sv
src/sdram_memory.sv
src/eeprom_memory.sv
src/cart_led.sv
src/cart_core.sv
test/cart_core_properties.sv
test/tb_cart_core.sv
